//--- source/rename_pkg.sv
// rename package: logical register count, instruction kinds, request and pass-along structs
package rename_pkg;

    // architectural register file size, r0 is hardwired to physical tag 0
    parameter int num_lregs = 32;

    typedef logic [4:0] lreg_t;

    // branch, load and store each take a map checkpoint
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1,
        kind_load   = 2'd2,
        kind_store  = 2'd3
    } inst_kind_e;

    // one decoded instruction as delivered by the decoder
    typedef struct packed {
        inst_kind_e  kind;
        lreg_t       lrd;
        lreg_t       lrj;
        lreg_t       lrk;
        logic [31:0] pc;
        logic [31:0] imm;
    } rename_req_t;

    // payload that rides along with the renamed tags
    typedef struct packed {
        inst_kind_e  kind;
        logic [31:0] pc;
        logic [31:0] imm;
    } pass_t;

    function automatic logic needs_checkpoint(inst_kind_e kind);
        return kind != kind_alu;
    endfunction

endpackage

//--- source/free_list.sv
// free_list: physical tag bitmap with lowest/highest pick, retire release and snapshot load
`timescale 1ns/10ps

module free_list #(
    parameter int log_pregs = 6
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   alloc0,
    input  logic                   alloc1,
    input  logic                   release0_v,
    input  logic                   release1_v,
    input  logic [log_pregs-1:0]   release0,
    input  logic [log_pregs-1:0]   release1,
    input  logic                   load_en,
    input  logic [2**log_pregs-1:0] load_bits,
    input  logic [log_pregs:0]     load_count,
    output logic [log_pregs-1:0]   pick0,
    output logic [log_pregs-1:0]   pick1,
    output logic [2**log_pregs-1:0] bits,
    output logic [log_pregs:0]     count
);
    import rename_pkg::*;

    localparam int num_tags = 2**log_pregs;

    logic [num_tags-1:0] bits_nxt;
    logic [log_pregs:0]  count_nxt;

    // slot 0 takes the lowest free tag, slot 1 the highest
    always_comb begin
        pick0 = '0;
        pick1 = '0;
        for (int i = num_tags - 1; i >= 0; i--) begin
            if (bits[i]) pick0 = log_pregs'(i);
        end
        for (int i = 0; i < num_tags; i++) begin
            if (bits[i]) pick1 = log_pregs'(i);
        end
    end

    // releases and picks never touch the same tag, order does not matter
    always_comb begin
        bits_nxt = bits;
        if (release0_v) bits_nxt[release0] = 1'b1;
        if (release1_v) bits_nxt[release1] = 1'b1;
        if (alloc0) bits_nxt[pick0] = 1'b0;
        if (alloc1) bits_nxt[pick1] = 1'b0;
        count_nxt = count + release0_v + release1_v - alloc0 - alloc1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_tags; i++) begin
                bits[i] <= (i >= num_lregs);
            end
            count <= (log_pregs + 1)'(num_tags - num_lregs);
        end else if (load_en) begin
            // restore overrides any release in the same cycle
            bits  <= load_bits;
            count <= load_count;
        end else begin
            bits  <= bits_nxt;
            count <= count_nxt;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) count <= num_tags);

    // acceptance upstream must hold off allocation while the list is empty
    assert property (@(posedge clk) disable iff (!rstn) (alloc0 || alloc1) |-> (|bits));

endmodule

//--- source/map_table.sv
// map_table: speculative logical-to-physical map with slot forwarding and snapshot load
`timescale 1ns/10ps

module map_table #(
    parameter int log_pregs = 6
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  rename_pkg::lreg_t       lrd0,
    input  rename_pkg::lreg_t       lrj0,
    input  rename_pkg::lreg_t       lrk0,
    input  rename_pkg::lreg_t       lrd1,
    input  rename_pkg::lreg_t       lrj1,
    input  rename_pkg::lreg_t       lrk1,
    input  logic                    wr0,
    input  logic                    wr1,
    input  logic [log_pregs-1:0]    new0,
    input  logic [log_pregs-1:0]    new1,
    input  logic                    load_en,
    input  logic [rename_pkg::num_lregs*log_pregs-1:0] load_map,
    output logic [log_pregs-1:0]    prj0,
    output logic [log_pregs-1:0]    prk0,
    output logic [log_pregs-1:0]    prr0,
    output logic [log_pregs-1:0]    prj1,
    output logic [log_pregs-1:0]    prk1,
    output logic [log_pregs-1:0]    prr1,
    output logic [rename_pkg::num_lregs*log_pregs-1:0] map_flat
);
    import rename_pkg::*;

    logic [num_lregs-1:0][log_pregs-1:0] map;

    assign map_flat = map;

    // slot 0 reads the map as it stands
    assign prj0 = map[lrj0];
    assign prk0 = map[lrk0];
    assign prr0 = map[lrd0];

    // slot 1 sees slot 0's new destination, wr0 is already low for r0
    assign prj1 = (wr0 && lrj1 == lrd0) ? new0 : map[lrj1];
    assign prk1 = (wr0 && lrk1 == lrd0) ? new0 : map[lrk1];
    // same lrd in both slots frees slot 0's fresh tag at slot 1's retirement
    assign prr1 = (wr0 && lrd1 == lrd0) ? new0 : map[lrd1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_lregs; i++) begin
                map[i] <= log_pregs'(i);
            end
        end else if (load_en) begin
            map <= load_map;
        end else begin
            if (wr0) map[lrd0] <= new0;
            // slot 1 is younger and wins on a shared lrd
            if (wr1) map[lrd1] <= new1;
        end
    end

    // r0 stays on tag 0 through renames and restores
    assert property (@(posedge clk) disable iff (!rstn) map[0] == '0);

endmodule

//--- source/checkpoint_store.sv
// checkpoint_store: ring of map and free-list snapshots with free count and restore read-out
`timescale 1ns/10ps

module checkpoint_store #(
    parameter int log_pregs       = 6,
    parameter int log_checkpoints = 2
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         take,
    input  logic [rename_pkg::num_lregs*log_pregs-1:0] snap_map,
    input  logic [2**log_pregs-1:0]      snap_bits,
    input  logic [log_pregs:0]           snap_count,
    input  logic                         rel0,
    input  logic                         rel1,
    input  logic                         restore_en,
    input  logic [log_checkpoints-1:0]   restore_idx,
    output logic [rename_pkg::num_lregs*log_pregs-1:0] restore_map,
    output logic [2**log_pregs-1:0]      restore_bits,
    output logic [log_pregs:0]           restore_count,
    output logic [log_checkpoints-1:0]   index,
    output logic                         any_free
);
    import rename_pkg::*;

    localparam int num_ckpts = 2**log_checkpoints;

    logic [num_lregs*log_pregs-1:0] map_mem   [num_ckpts];
    logic [2**log_pregs-1:0]        bits_mem  [num_ckpts];
    logic [log_pregs:0]             count_mem [num_ckpts];
    logic [log_checkpoints:0]       free_ckpts;

    assign any_free = free_ckpts != '0;

    assign restore_map   = map_mem[restore_idx];
    assign restore_bits  = bits_mem[restore_idx];
    assign restore_count = count_mem[restore_idx];

    // snapshot storage
    always_ff @(posedge clk) begin
        if (take) begin
            map_mem[index]   <= snap_map;
            bits_mem[index]  <= snap_bits;
            count_mem[index] <= snap_count;
        end
    end

    // a restore discards every younger checkpoint, so the ring starts over
    always_ff @(posedge clk) begin
        if (!rstn || restore_en) begin
            free_ckpts <= (log_checkpoints + 1)'(num_ckpts);
            index      <= '0;
        end else begin
            free_ckpts <= free_ckpts + rel0 + rel1 - take;
            if (take) index <= index + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) take |-> any_free);

    assert property (@(posedge clk) disable iff (!rstn) free_ckpts <= num_ckpts);

endmodule

//--- source/rename_stage.sv
// rename_stage: acceptance control, output registers and the free list, map and checkpoint blocks
`timescale 1ns/10ps

module rename_stage #(
    parameter int log_pregs       = 6,
    parameter int log_checkpoints = 2
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       stall,
    input  rename_pkg::rename_req_t    req0,
    input  rename_pkg::rename_req_t    req1,
    input  logic                       restore_en,
    input  logic [log_checkpoints-1:0] restore_checkpoint,
    input  logic [log_pregs-1:0]       rt0_prr,
    input  logic                       rt0_prr_v,
    input  logic [log_pregs-1:0]       rt1_prr,
    input  logic                       rt1_prr_v,
    input  logic                       rt0_release_checkpoint,
    input  logic                       rt1_release_checkpoint,
    output logic [1:0]                 num_read,
    output logic                       inst0_valid,
    output logic [log_pregs-1:0]       prd0,
    output logic                       prd0_v,
    output logic [log_pregs-1:0]       prj0,
    output logic                       prj0_v,
    output logic [log_pregs-1:0]       prk0,
    output logic                       prk0_v,
    output logic [log_pregs-1:0]       prr0,
    output logic                       prr0_v,
    output logic [log_checkpoints-1:0] checkpoint0,
    output rename_pkg::pass_t          pass0,
    output logic                       inst1_valid,
    output logic [log_pregs-1:0]       prd1,
    output logic                       prd1_v,
    output logic [log_pregs-1:0]       prj1,
    output logic                       prj1_v,
    output logic [log_pregs-1:0]       prk1,
    output logic                       prk1_v,
    output logic [log_pregs-1:0]       prr1,
    output logic                       prr1_v,
    output logic [log_checkpoints-1:0] checkpoint1,
    output rename_pkg::pass_t          pass1
);
    import rename_pkg::*;

    logic                       ck0;
    logic                       ck1;
    logic                       acc0;
    logic                       acc1;
    logic                       wr0;
    logic                       wr1;
    logic                       take;
    logic [log_pregs-1:0]       pick0;
    logic [log_pregs-1:0]       pick1;
    logic [2**log_pregs-1:0]    fl_bits;
    logic [log_pregs:0]         fl_count;
    logic [num_lregs*log_pregs-1:0] map_flat;
    logic [log_pregs-1:0]       map_prj0;
    logic [log_pregs-1:0]       map_prk0;
    logic [log_pregs-1:0]       map_prr0;
    logic [log_pregs-1:0]       map_prj1;
    logic [log_pregs-1:0]       map_prk1;
    logic [log_pregs-1:0]       map_prr1;
    logic [num_lregs*log_pregs-1:0] rs_map;
    logic [2**log_pregs-1:0]    rs_bits;
    logic [log_pregs:0]         rs_count;
    logic [log_checkpoints-1:0] ck_index;
    logic                       ck_any_free;

    assign ck0 = needs_checkpoint(req0.kind);
    assign ck1 = needs_checkpoint(req1.kind);

    // nothing is taken in a restore cycle
    assign acc0 = !stall && !restore_en && fl_count >= 1 && (!(ck0 || ck1) || ck_any_free);
    // slot 1 only follows an accepted slot 0, so 2'b10 never occurs
    assign acc1 = acc0 && fl_count >= 2 && !ck0;
    assign num_read = {acc1, acc0};

    assign wr0  = acc0 && req0.lrd != '0;
    assign wr1  = acc1 && req1.lrd != '0;
    assign take = (acc0 && ck0) || (acc1 && ck1);

    free_list #(.log_pregs(log_pregs)) free_list_inst (
        .clk(clk), .rstn(rstn),
        .alloc0(wr0), .alloc1(wr1),
        .release0_v(rt0_prr_v), .release1_v(rt1_prr_v),
        .release0(rt0_prr), .release1(rt1_prr),
        .load_en(restore_en), .load_bits(rs_bits), .load_count(rs_count),
        .pick0(pick0), .pick1(pick1), .bits(fl_bits), .count(fl_count)
    );

    map_table #(.log_pregs(log_pregs)) map_table_inst (
        .clk(clk), .rstn(rstn),
        .lrd0(req0.lrd), .lrj0(req0.lrj), .lrk0(req0.lrk),
        .lrd1(req1.lrd), .lrj1(req1.lrj), .lrk1(req1.lrk),
        .wr0(wr0), .wr1(wr1), .new0(pick0), .new1(pick1),
        .load_en(restore_en), .load_map(rs_map),
        .prj0(map_prj0), .prk0(map_prk0), .prr0(map_prr0),
        .prj1(map_prj1), .prk1(map_prk1), .prr1(map_prr1),
        .map_flat(map_flat)
    );

    // snapshot is the state before the pair is applied
    checkpoint_store #(
        .log_pregs(log_pregs),
        .log_checkpoints(log_checkpoints)
    ) checkpoint_store_inst (
        .clk(clk), .rstn(rstn), .take(take),
        .snap_map(map_flat), .snap_bits(fl_bits), .snap_count(fl_count),
        .rel0(rt0_release_checkpoint), .rel1(rt1_release_checkpoint),
        .restore_en(restore_en), .restore_idx(restore_checkpoint),
        .restore_map(rs_map), .restore_bits(rs_bits), .restore_count(rs_count),
        .index(ck_index), .any_free(ck_any_free)
    );

    // control outputs
    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst0_valid <= 1'b0;
            inst1_valid <= 1'b0;
            {prd0_v, prj0_v, prk0_v, prr0_v} <= '0;
            {prd1_v, prj1_v, prk1_v, prr1_v} <= '0;
        end else begin
            inst0_valid <= acc0;
            inst1_valid <= acc1;
            prd0_v <= wr0;
            prr0_v <= wr0;
            prj0_v <= acc0 && req0.lrj != '0;
            prk0_v <= acc0 && req0.lrk != '0;
            prd1_v <= wr1;
            prr1_v <= wr1;
            prj1_v <= acc1 && req1.lrj != '0;
            prk1_v <= acc1 && req1.lrk != '0;
        end
    end

    // tags and payload
    always_ff @(posedge clk) begin
        prd0 <= pick0;
        prj0 <= map_prj0;
        prk0 <= map_prk0;
        prr0 <= map_prr0;
        prd1 <= pick1;
        prj1 <= map_prj1;
        prk1 <= map_prk1;
        prr1 <= map_prr1;
        checkpoint0 <= ck_index;
        checkpoint1 <= ck_index;
        pass0 <= '{kind: req0.kind, pc: req0.pc, imm: req0.imm};
        pass1 <= '{kind: req1.kind, pc: req1.pc, imm: req1.imm};
    end

endmodule

//--- source/rename_top.sv
// rename_top: top level of the rename stage, sets tag and checkpoint widths
`timescale 1ns/10ps

module rename_top #(
    parameter int log_pregs       = 6,
    parameter int log_checkpoints = 2
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       stall,
    input  rename_pkg::rename_req_t    req0,
    input  rename_pkg::rename_req_t    req1,
    input  logic                       restore_en,
    input  logic [log_checkpoints-1:0] restore_checkpoint,
    input  logic [log_pregs-1:0]       rt0_prr,
    input  logic                       rt0_prr_v,
    input  logic [log_pregs-1:0]       rt1_prr,
    input  logic                       rt1_prr_v,
    input  logic                       rt0_release_checkpoint,
    input  logic                       rt1_release_checkpoint,
    output logic [1:0]                 num_read,
    output logic                       inst0_valid,
    output logic [log_pregs-1:0]       prd0,
    output logic                       prd0_v,
    output logic [log_pregs-1:0]       prj0,
    output logic                       prj0_v,
    output logic [log_pregs-1:0]       prk0,
    output logic                       prk0_v,
    output logic [log_pregs-1:0]       prr0,
    output logic                       prr0_v,
    output logic [log_checkpoints-1:0] checkpoint0,
    output rename_pkg::pass_t          pass0,
    output logic                       inst1_valid,
    output logic [log_pregs-1:0]       prd1,
    output logic                       prd1_v,
    output logic [log_pregs-1:0]       prj1,
    output logic                       prj1_v,
    output logic [log_pregs-1:0]       prk1,
    output logic                       prk1_v,
    output logic [log_pregs-1:0]       prr1,
    output logic                       prr1_v,
    output logic [log_checkpoints-1:0] checkpoint1,
    output rename_pkg::pass_t          pass1
);

    // 64 physical tags, 4 checkpoints by default
    rename_stage #(
        .log_pregs(log_pregs),
        .log_checkpoints(log_checkpoints)
    ) rename_stage_inst (.*);

endmodule

//--- testbench/rename_model.svh
// reference model of the rename map, the free-tag bitmap and the checkpoint ring
`ifndef rename_model_svh
`define rename_model_svh

// state as it stands after the last modeled clock edge
logic [num_lregs-1:0][log_pregs-1:0] m_map;
logic [num_tags-1:0]                 m_bits;
int                                  m_count;
logic [log_checkpoints-1:0]          m_ck_index;
int                                  m_ck_free;
// snapshots written since the last restore, only these may be restored
int                                  m_snaps;
logic [num_lregs-1:0][log_pregs-1:0] m_snap_map [num_ckpts];
logic [num_tags-1:0]                 m_snap_bits [num_ckpts];
int                                  m_snap_count [num_ckpts];

function automatic logic needs_snapshot(input inst_kind_e kind);
    return kind == kind_branch || kind == kind_load || kind == kind_store;
endfunction

function automatic logic [log_pregs-1:0] lowest_free();
    for (int t = 0; t < num_tags; t++) begin
        if (m_bits[t]) return log_pregs'(t);
    end
    return '0;
endfunction

function automatic logic [log_pregs-1:0] highest_free();
    for (int t = num_tags - 1; t >= 0; t--) begin
        if (m_bits[t]) return log_pregs'(t);
    end
    return '0;
endfunction

function automatic logic is_mapped(input logic [log_pregs-1:0] tag);
    for (int i = 0; i < num_lregs; i++) begin
        if (m_map[i] == tag) return 1'b1;
    end
    return 1'b0;
endfunction

task automatic reset_model();
    for (int i = 0; i < num_lregs; i++) begin
        m_map[i] = log_pregs'(i);
    end
    for (int t = 0; t < num_tags; t++) begin
        m_bits[t] = (t >= num_lregs);
    end
    m_count = num_tags - num_lregs;
    m_ck_index = '0;
    m_ck_free = num_ckpts;
    m_snaps = 0;
endtask

// expected registered outputs of one slot, read through the given view of the map
function automatic slot_t rename_slot(input logic acc, input logic wr, input rename_req_t q,
        input logic [log_pregs-1:0] tag, input logic [num_lregs-1:0][log_pregs-1:0] view);
    slot_t s;
    s.valid = acc;
    s.prd = tag;
    s.prd_v = wr;
    s.prj = view[q.lrj];
    s.prj_v = acc && q.lrj != '0;
    s.prk = view[q.lrk];
    s.prk_v = acc && q.lrk != '0;
    s.prr = view[q.lrd];
    s.prr_v = wr;
    s.ck = m_ck_index;
    s.pass.kind = q.kind;
    s.pass.pc = q.pc;
    s.pass.imm = q.imm;
    return s;
endfunction

task automatic step_model(input logic stall_i, input rename_req_t q0, input rename_req_t q1,
        input logic rs_en, input int rs_idx,
        input logic [log_pregs-1:0] rel0, input logic rel0_v,
        input logic [log_pregs-1:0] rel1, input logic rel1_v,
        input logic ck_rel0, input logic ck_rel1, output exp_t e);
    logic ck0, ck1, acc0, acc1, wr0, wr1, take;
    logic [log_pregs-1:0] p0, p1;
    logic [num_lregs-1:0][log_pregs-1:0] view;
    ck0 = needs_snapshot(q0.kind);
    ck1 = needs_snapshot(q1.kind);
    acc0 = !stall_i && !rs_en && m_count >= 1 && (!(ck0 || ck1) || m_ck_free > 0);
    acc1 = acc0 && m_count >= 2 && !ck0;
    wr0 = acc0 && q0.lrd != '0;
    wr1 = acc1 && q1.lrd != '0;
    take = (acc0 && ck0) || (acc1 && ck1);
    p0 = lowest_free();
    p1 = highest_free();
    // slot 1 reads the map with slot 0's write already applied
    view = m_map;
    if (wr0) view[q0.lrd] = p0;
    e.num_read = {acc1, acc0};
    e.s0 = rename_slot(acc0, wr0, q0, p0, m_map);
    e.s1 = rename_slot(acc1, wr1, q1, p1, view);
    if (rs_en) begin
        m_map = m_snap_map[rs_idx];
        m_bits = m_snap_bits[rs_idx];
        m_count = m_snap_count[rs_idx];
        m_ck_index = '0;
        m_ck_free = num_ckpts;
        m_snaps = 0;
    end else begin
        // snapshot holds the state from before the pair
        if (take) begin
            m_snap_map[m_ck_index] = m_map;
            m_snap_bits[m_ck_index] = m_bits;
            m_snap_count[m_ck_index] = m_count;
            if (m_snaps < num_ckpts) m_snaps++;
        end
        if (rel0_v) m_bits[rel0] = 1'b1;
        if (rel1_v) m_bits[rel1] = 1'b1;
        if (wr0) m_bits[p0] = 1'b0;
        if (wr1) m_bits[p1] = 1'b0;
        m_count = m_count + rel0_v + rel1_v - wr0 - wr1;
        m_map = view;
        if (wr1) m_map[q1.lrd] = p1;
        m_ck_free = m_ck_free + ck_rel0 + ck_rel1 - take;
        if (take) m_ck_index++;
    end
endtask

`endif

//--- testbench/rename_tb.sv
// rename_tb: clock, reset, random rename traffic with retires and restores, output checks
`timescale 1ns/10ps

module rename_tb;
    import rename_pkg::*;

    localparam int log_pregs       = 6;
    localparam int log_checkpoints = 2;
    localparam int num_tags        = 2**log_pregs;
    localparam int num_ckpts       = 2**log_checkpoints;
    localparam int num_cycles      = 2000;
    // stimulus plus reset, the final drain and headroom
    localparam int cycle_limit     = num_cycles + 1000;

    typedef struct packed {
        logic                       valid;
        logic [log_pregs-1:0]       prd;
        logic                       prd_v;
        logic [log_pregs-1:0]       prj;
        logic                       prj_v;
        logic [log_pregs-1:0]       prk;
        logic                       prk_v;
        logic [log_pregs-1:0]       prr;
        logic                       prr_v;
        logic [log_checkpoints-1:0] ck;
        pass_t                      pass;
    } slot_t;

    typedef struct packed {
        logic [1:0] num_read;
        slot_t      s0;
        slot_t      s1;
    } exp_t;

    logic clk, rstn, stall, restore_en;
    rename_req_t req0, req1;
    logic [log_checkpoints-1:0] restore_checkpoint, checkpoint0, checkpoint1;
    logic [log_pregs-1:0] rt0_prr, rt1_prr;
    logic rt0_prr_v, rt1_prr_v, rt0_release_checkpoint, rt1_release_checkpoint;
    logic [1:0] num_read;
    logic inst0_valid, prd0_v, prj0_v, prk0_v, prr0_v;
    logic inst1_valid, prd1_v, prj1_v, prk1_v, prr1_v;
    logic [log_pregs-1:0] prd0, prj0, prk0, prr0, prd1, prj1, prk1, prr1;
    pass_t pass0, pass1;

    // old tags waiting for retirement
    logic [log_pregs-1:0] free_q[$];
    logic [31:0] seed = 32'h658fe44c;
    int cycles = 0;

    `include "rename_model.svh"

    rename_top #(
        .log_pregs(log_pregs),
        .log_checkpoints(log_checkpoints)
    ) rename_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic int unsigned next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'd0, seed[31:16]};
    endfunction

    function automatic logic chance(input int unsigned num, input int unsigned den);
        return (next_rand() % den) < num;
    endfunction

    function automatic lreg_t pick_lreg();
        int unsigned r;
        r = next_rand();
        // narrow range half the time, gives r0 and slot-to-slot matches
        return r[15] ? lreg_t'(r) : lreg_t'(r % 4);
    endfunction

    function automatic rename_req_t random_req();
        rename_req_t q;
        int unsigned r;
        r = next_rand();
        q.kind = r[2] ? kind_alu : inst_kind_e'(r[1:0]);
        q.lrd = pick_lreg();
        q.lrj = pick_lreg();
        q.lrk = pick_lreg();
        q.pc = (next_rand() << 16) | next_rand();
        q.imm = (next_rand() << 16) | next_rand();
        return q;
    endfunction

    // in flight after a restore: neither free nor held by the restored map
    task automatic rebuild_queue();
        free_q.delete();
        for (int t = 0; t < num_tags; t++) begin
            if (!m_bits[t] && !is_mapped(log_pregs'(t))) free_q.push_back(log_pregs'(t));
        end
    endtask

    task automatic compare(input string name, input logic [65:0] got, input logic [65:0] want);
        if (got !== want) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, want);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_slot(input int s, input slot_t got, input slot_t want);
        compare($sformatf("inst%0d_valid", s), 66'(got.valid), 66'(want.valid));
        compare($sformatf("prd%0d_v", s), 66'(got.prd_v), 66'(want.prd_v));
        compare($sformatf("prj%0d_v", s), 66'(got.prj_v), 66'(want.prj_v));
        compare($sformatf("prk%0d_v", s), 66'(got.prk_v), 66'(want.prk_v));
        compare($sformatf("prr%0d_v", s), 66'(got.prr_v), 66'(want.prr_v));
        if (want.valid) begin
            compare($sformatf("prj%0d", s), 66'(got.prj), 66'(want.prj));
            compare($sformatf("prk%0d", s), 66'(got.prk), 66'(want.prk));
            compare($sformatf("checkpoint%0d", s), 66'(got.ck), 66'(want.ck));
            compare($sformatf("pass%0d", s), 66'(got.pass), 66'(want.pass));
            if (want.prd_v) compare($sformatf("prd%0d", s), 66'(got.prd), 66'(want.prd));
            if (want.prr_v) compare($sformatf("prr%0d", s), 66'(got.prr), 66'(want.prr));
        end
    endtask

    task automatic check_outputs(input exp_t want);
        check_slot(0, {inst0_valid, prd0, prd0_v, prj0, prj0_v, prk0, prk0_v, prr0, prr0_v,
                       checkpoint0, pass0}, want.s0);
        check_slot(1, {inst1_valid, prd1, prd1_v, prj1, prj1_v, prk1, prk1_v, prr1, prr1_v,
                       checkpoint1, pass1}, want.s1);
    endtask

    initial begin
        exp_t now_exp, prev_exp;
        rename_req_t q0, q1;
        logic st, rs, c0, c1, t0v, t1v;
        logic [log_pregs-1:0] t0, t1;
        int rs_idx, rate, idx;
        rstn = 1'b0;
        stall = 1'b1;
        req0 = '0;
        req1 = '0;
        restore_en = 1'b0;
        restore_checkpoint = '0;
        {rt0_prr, rt0_prr_v, rt1_prr, rt1_prr_v} = '0;
        {rt0_release_checkpoint, rt1_release_checkpoint} = '0;
        reset_model();
        prev_exp = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            q0 = random_req();
            q1 = random_req();
            st = chance(1, 8);
            if (cyc == 0) begin
                // first pair draws from the reset free list
                st = 1'b0;
                q0.kind = kind_alu;
                q0.lrd = 5'd1;
                q1.kind = kind_alu;
                q1.lrd = 5'd2;
            end
            rs = m_snaps > 0 && chance(1, 64);
            rs_idx = 0;
            if (rs) rs_idx = int'(next_rand() % m_snaps);
            {t0, t0v, t1, t1v} = '0;
            // phases of sparse retirement run the free list dry
            rate = ((cyc / 200) % 2 == 0) ? 2 : 7;
            if (!rs && free_q.size() > 0 && chance(rate, 8)) begin
                idx = int'(next_rand() % free_q.size());
                t0 = free_q[idx];
                t0v = 1'b1;
                free_q.delete(idx);
            end
            if (!rs && free_q.size() > 0 && chance(rate, 8)) begin
                idx = int'(next_rand() % free_q.size());
                t1 = free_q[idx];
                t1v = 1'b1;
                free_q.delete(idx);
            end
            c0 = !rs && (num_ckpts - m_ck_free) >= 1 && chance(1, 4);
            c1 = !rs && (num_ckpts - m_ck_free) >= 2 && chance(1, 4);
            stall <= st;
            req0 <= q0;
            req1 <= q1;
            restore_en <= rs;
            restore_checkpoint <= log_checkpoints'(rs_idx);
            rt0_prr <= t0;
            rt0_prr_v <= t0v;
            rt1_prr <= t1;
            rt1_prr_v <= t1v;
            rt0_release_checkpoint <= c0;
            rt1_release_checkpoint <= c1;
            step_model(st, q0, q1, rs, rs_idx, t0, t0v, t1, t1v, c0, c1, now_exp);
            if (now_exp.s0.prr_v) free_q.push_back(now_exp.s0.prr);
            if (now_exp.s1.prr_v) free_q.push_back(now_exp.s1.prr);
            if (rs) rebuild_queue();
            @(negedge clk);
            compare("num_read", 66'(num_read), 66'(now_exp.num_read));
            check_outputs(prev_exp);
            if (cyc == 1) begin
                compare("prd0", 66'(prd0), 66'd32);
                compare("prd1", 66'(prd1), 66'd63);
            end
            prev_exp = now_exp;
        end
        @(posedge clk);
        @(negedge clk);
        check_outputs(prev_exp);
        $display("Everything OK");
        $finish;
    end

endmodule

//--- rename_sys.f
+incdir+testbench
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/checkpoint_store.sv
source/rename_stage.sv
source/rename_top.sv
testbench/rename_tb.sv

//--- Bender.yml
package:
  name: rename_sys

sources:
  - source/rename_pkg.sv
  - source/free_list.sv
  - source/map_table.sv
  - source/checkpoint_store.sv
  - source/rename_stage.sv
  - source/rename_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/rename_tb.sv
